//--- flist.f
+incdir+verif
hw/rom_scr_pkg.sv
hw/addr_subst_perm.sv
hw/keystream_cipher.sv
hw/rom_storage.sv
hw/scrambled_rom.sv
hw/rom_scr_top.sv
verif/rom_scr_checker.sv
verif/tb_rom_scr.sv

//--- run.sh
#!/bin/sh
# Build and run the scrambled ROM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rom_scr -f flist.f

# Assertion errors are counted by the bench, which then ends the run with $fatal
./obj_dir/Vtb_rom_scr +verilator+error+limit+100

//--- rom_image.hex
// One 40-bit scrambled word per line, physical rows 0 to 15
3a7c19e0f2
b41f7c0e93
05d2e88a61
c9a0374b1d
7e6b52f0c8
1d94a3e675
e2f80c5b39
6c1be7240a
92d5f61c8e
48a93d07b6
f07e2a9153
2b6dc48e07
a5c1903f7d
5f387be2c4
d83e65a14b
0ac4f9d728

//--- verif/rom_scr_model.svh
/* Reference model: ROM image, address permutation and keystream
   derived from the scrambling rules */

// Image as stored, in physical row order
word_t model_image [Depth];

initial begin
  $readmemh(MemInitFile, model_image);
end

// Two rounds of key XOR, S-box and one-bit left rotation
function automatic addr_t model_addr_perm(addr_t a);
  addr_t key;
  addr_t s;
  key = ScrNonce[63:60];
  s = a;
  for (int r = 0; r < 2; r++) begin
    s = s ^ key;
    s = SBox[s];
    s = {s[2:0], s[3]};
  end
  return s;
endfunction

// Four SP rounds over nonce and address, then a last k0 XOR
function automatic block_t model_keystream(addr_t pa);
  block_t st;
  block_t k0;
  block_t k1;
  k0 = ScrKey[127:64];
  k1 = ScrKey[63:0];
  st = {ScrNonce[59:0], pa};
  for (int r = 0; r < 4; r++) begin
    st = st ^ ((r % 2 == 0) ? k0 : k1) ^ RoundConst[r];
    for (int n = 0; n < 16; n++) begin
      st[4*n +: 4] = SBox[st[4*n +: 4]];
    end
    // Left rotation by 13
    st = {st[50:0], st[63:51]};
  end
  return st ^ k0;
endfunction

//--- verif/tb_rom_scr.sv
/* Scrambled ROM testbench with clock, reset, three stimulus
   phases, sweep row coverage and timeout */

module tb_rom_scr;

  import rom_scr_pkg::*;

  `include "rom_scr_model.svh"

  localparam int ResetCycles = 2;
  localparam int NumRandom   = 40;
  localparam int NumMismatch = 8;
  // Twice the longest stimulus where every random read adds an idle cycle
  localparam int TimeoutCycles = 2 * (ResetCycles + Depth + 2 * NumRandom + NumMismatch);

  logic  clk_i;
  logic  reset_i;
  logic  req_i;
  addr_t rom_addr_i;
  addr_t prince_addr_i;
  logic  rvalid_o;
  word_t scr_rdata_o;
  word_t clr_rdata_o;

  int               req_count   = 0;
  int               resp_count  = 0;
  int               cycle_count = 0;
  integer           seed        = 12;
  logic [Depth-1:0] seen_rows   = '0;

  rom_scr_top dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .rom_addr_i    (rom_addr_i),
    .prince_addr_i (prince_addr_i),
    .rvalid_o      (rvalid_o),
    .scr_rdata_o   (scr_rdata_o),
    .clr_rdata_o   (clr_rdata_o)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Failure handling
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("error %s: expected %h actual %h", test, exp, act);
    abort_run("value mismatch");
  endtask

  always @(negedge clk_i) begin
    if (dut.u_checker.any_fail) begin
      abort_run("an assertion on rom_scr_top failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      abort_run("timeout, not all read responses arrived in time");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and response tracking
  ////////////////////////////////////////////////////////////

  task automatic issue_read(input addr_t ra, input addr_t pa);
    @(posedge clk_i);
    #10;
    req_i         = 1'b1;
    rom_addr_i    = ra;
    prince_addr_i = pa;
    req_count++;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #10;
    req_i = 1'b0;
  endtask

  // Mark the image row that holds a returned word
  task automatic mark_row(input word_t w);
    for (int r = 0; r < Depth; r++) begin
      if (model_image[r] == w) begin
        seen_rows[r] = 1'b1;
      end
    end
  endtask

  // First Depth responses belong to the sweep
  always @(negedge clk_i) begin
    if (!reset_i && rvalid_o) begin
      if (resp_count < Depth) begin
        mark_row(scr_rdata_o);
      end
      resp_count++;
    end
  end

  initial begin
    logic [31:0] rnd;
    addr_t       ra;
    addr_t       pa;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    // Request held high in reset, which must still keep rvalid_o low
    req_i         = 1'b1;
    rom_addr_i    = '0;
    prince_addr_i = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    req_i   = 1'b0;

    // Sweep with equal copies and one read per cycle
    for (int a = 0; a < Depth; a++) begin
      issue_read(addr_t'(a), addr_t'(a));
    end

    // Random reads that sometimes differ in their copies or leave an idle gap
    for (int i = 0; i < NumRandom; i++) begin
      rnd = $random(seed);
      ra  = rnd[3:0];
      pa  = rnd[4] ? rnd[11:8] : rnd[3:0];
      issue_read(ra, pa);
      if (rnd[13:12] == 2'b00) begin
        idle_cycle();
      end
    end

    // Copies always differ here
    for (int i = 0; i < NumMismatch; i++) begin
      ra = addr_t'(3 * i + 1);
      pa = ra ^ addr_t'(i + 1);
      issue_read(ra, pa);
    end
    idle_cycle();

    while (resp_count < req_count) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);

    // A bijective permutation returns every physical row once
    assert (seen_rows == {Depth{1'b1}})
      else report_mismatch("address_sweep", 64'({Depth{1'b1}}), 64'(seen_rows));

    if (dut.u_checker.any_fail) begin
      abort_run("an assertion on rom_scr_top failed");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- verif/rom_scr_checker.sv
/* Concurrent assertions on the scrambled ROM top level:
   reset, read latency, scrambled and clear data */

module rom_scr_checker (
  input logic               clk_i,
  input logic               reset_i,
  input logic               req_i,
  input rom_scr_pkg::addr_t rom_addr_i,
  input rom_scr_pkg::addr_t prince_addr_i,
  input logic               rvalid_o,
  input rom_scr_pkg::word_t scr_rdata_o,
  input rom_scr_pkg::word_t clr_rdata_o
);

  import rom_scr_pkg::*;

  `include "rom_scr_model.svh"

  // Address copies of the request one cycle back
  addr_t rom_addr_q;
  addr_t prince_addr_q;

  always_ff @(posedge clk_i) begin
    rom_addr_q    <= rom_addr_i;
    prince_addr_q <= prince_addr_i;
  end

  ////////////////////////////////////////////////////////////
  // Expected response
  ////////////////////////////////////////////////////////////

  word_t  exp_scr;
  word_t  exp_clr;
  block_t exp_ks;

  always_comb begin
    exp_scr = model_image[model_addr_perm(rom_addr_q)];
    exp_ks  = model_keystream(prince_addr_q);
    exp_clr = exp_scr ^ exp_ks[Width-1:0];
  end

  // One flag per assertion, raised on failure
  logic reset_fail = 1'b0;
  logic valid_fail = 1'b0;
  logic idle_fail  = 1'b0;
  logic scr_fail   = 1'b0;
  logic clr_fail   = 1'b0;
  logic any_fail;

  assign any_fail = reset_fail | valid_fail | idle_fail | scr_fail | clr_fail;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !rvalid_o)
    else begin
      $error("error reset_valid: expected 0 actual %b", $sampled(rvalid_o));
      reset_fail = 1'b1;
    end

  // One-cycle latency, back-to-back requests included
  req_gives_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |=> rvalid_o)
    else begin
      $error("error read_latency: expected 1 actual %b", $sampled(rvalid_o));
      valid_fail = 1'b1;
    end

  no_spurious_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_i |=> !rvalid_o)
    else begin
      $error("error idle_valid: expected 0 actual %b", $sampled(rvalid_o));
      idle_fail = 1'b1;
    end

  scr_data_matches: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> scr_rdata_o == exp_scr)
    else begin
      $error("error scr_data: expected %h actual %h", $sampled(exp_scr),
             $sampled(scr_rdata_o));
      scr_fail = 1'b1;
    end

  // Holds for equal and for differing address copies
  clr_data_matches: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> clr_rdata_o == exp_clr)
    else begin
      $error("error clr_data: expected %h actual %h", $sampled(exp_clr),
             $sampled(clr_rdata_o));
      clr_fail = 1'b1;
    end

endmodule

bind rom_scr_top rom_scr_checker u_checker (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .req_i         (req_i),
  .rom_addr_i    (rom_addr_i),
  .prince_addr_i (prince_addr_i),
  .rvalid_o      (rvalid_o),
  .scr_rdata_o   (scr_rdata_o),
  .clr_rdata_o   (clr_rdata_o)
);

//--- hw/rom_scr_top.sv
/* Top level of the scrambled boot ROM */

module rom_scr_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  rom_scr_pkg::addr_t rom_addr_i,
  input  rom_scr_pkg::addr_t prince_addr_i,
  output logic               rvalid_o,
  output rom_scr_pkg::word_t scr_rdata_o,
  output rom_scr_pkg::word_t clr_rdata_o
);

  import rom_scr_pkg::*;

  ////////////////////////////////////////////////////////////
  // Scrambled ROM instance
  ////////////////////////////////////////////////////////////

  // Fixed nonce and key from the package
  scrambled_rom #(
    .Nonce (ScrNonce),
    .Key   (ScrKey)
  ) u_scrambled_rom (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    // Both copies split upstream in the controller
    .rom_addr_i    (rom_addr_i),
    .prince_addr_i (prince_addr_i),
    // Read response, one cycle after req_i
    .rvalid_o      (rvalid_o),
    .scr_rdata_o   (scr_rdata_o),
    .clr_rdata_o   (clr_rdata_o)
  );

endmodule

//--- hw/scrambled_rom.sv
/* Scrambled ROM: address permutation, keystream cipher and
   physical ROM, giving scrambled and clear read data */

module scrambled_rom #(
  parameter rom_scr_pkg::block_t Nonce = rom_scr_pkg::ScrNonce,
  parameter rom_scr_pkg::key_t   Key   = rom_scr_pkg::ScrKey
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  rom_scr_pkg::addr_t rom_addr_i,
  input  rom_scr_pkg::addr_t prince_addr_i,
  output logic               rvalid_o,
  output rom_scr_pkg::word_t scr_rdata_o,
  output rom_scr_pkg::word_t clr_rdata_o
);

  import rom_scr_pkg::*;

  ////////////////////////////////////////////////////////////
  // Nonce split
  ////////////////////////////////////////////////////////////

  // Top bits key the address network, the rest tweak the keystream
  addr_t                 addr_key;
  logic [NonceWidth-1:0] data_nonce;

  assign addr_key   = Nonce[BlockWidth-1 -: Aw];
  assign data_nonce = Nonce[NonceWidth-1:0];

  // First address copy selects the physical row
  addr_t addr_scr;

  addr_subst_perm u_addr_perm (
    .addr_i (rom_addr_i),
    .key_i  (addr_key),
    .addr_o (addr_scr)
  );

  // Second address copy tweaks the keystream, valid_o duplicates the ROM valid
  block_t keystream;

  keystream_cipher u_cipher (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (req_i),
    .data_i  ({data_nonce, prince_addr_i}),
    .key_i   (Key),
    .data_o  (keystream),
    .valid_o ()
  );

  word_t rdata_scr;

  rom_storage u_rom (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .addr_i   (addr_scr),
    .rdata_o  (rdata_scr),
    .rvalid_o (rvalid_o)
  );

  // A fault on one address copy leaves the clear word as garbage
  assign scr_rdata_o = rdata_scr;
  assign clr_rdata_o = rdata_scr ^ keystream[Width-1:0];

endmodule

//--- hw/rom_storage.sv
/* Physical ROM array with registered read data and read valid */

module rom_storage (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  rom_scr_pkg::addr_t addr_i,
  output rom_scr_pkg::word_t rdata_o,
  output logic               rvalid_o
);

  import rom_scr_pkg::*;

  // Scrambled contents, rows in physical order
  word_t mem [Depth];

  initial begin
    $readmemh(MemInitFile, mem);
  end

  word_t rdata_q;
  logic  rvalid_q;

  // Read port, data holds while idle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  // One-cycle valid pulse per request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- hw/keystream_cipher.sv
/* Four-round 64-bit SP cipher producing the data keystream,
   with a pipeline register after the second round */

module keystream_cipher (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  rom_scr_pkg::block_t data_i,
  input  rom_scr_pkg::key_t   key_i,
  output rom_scr_pkg::block_t data_o,
  output logic                valid_o
);

  import rom_scr_pkg::*;

  // One round: add round key and constant, substitute, rotate
  function automatic block_t cipher_round(block_t s, block_t rk, block_t rc);
    block_t t;
    t = s ^ rk ^ rc;
    for (int n = 0; n < BlockWidth / 4; n++) begin
      t[4*n +: 4] = SBox[t[4*n +: 4]];
    end
    return {t[BlockWidth-1-CipherRot:0], t[BlockWidth-1:BlockWidth-CipherRot]};
  endfunction

  // Round keys, k0 on even rounds and k1 on odd rounds
  block_t k0;
  block_t k1;

  assign k0 = key_i[127:64];
  assign k1 = key_i[63:0];

  ////////////////////////////////////////////////////////////
  // First half, rounds 0 and 1
  ////////////////////////////////////////////////////////////

  block_t round0;
  block_t round1;

  assign round0 = cipher_round(data_i, k0, RoundConst[0]);
  assign round1 = cipher_round(round0, k1, RoundConst[1]);

  ////////////////////////////////////////////////////////////
  // Halfway register
  ////////////////////////////////////////////////////////////

  block_t half_q;
  logic   valid_q;

  // State only moves on a request so the output holds between reads
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      half_q <= round1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Second half, rounds 2 and 3 plus whitening
  ////////////////////////////////////////////////////////////

  block_t round2;
  block_t round3;

  assign round2 = cipher_round(half_q, k0, RoundConst[2]);
  assign round3 = cipher_round(round2, k1, RoundConst[3]);

  // Final key addition with k0
  assign data_o  = round3 ^ k0;
  assign valid_o = valid_q;

endmodule

//--- hw/addr_subst_perm.sv
/* Keyed substitution-permutation network on the word address */

module addr_subst_perm (
  input  rom_scr_pkg::addr_t addr_i,
  input  rom_scr_pkg::addr_t key_i,
  output rom_scr_pkg::addr_t addr_o
);

  import rom_scr_pkg::*;

  ////////////////////////////////////////////////////////////
  // Round network
  ////////////////////////////////////////////////////////////

  // Working value carried through the rounds
  addr_t state;

  always_comb begin
    state = addr_i;
    for (int r = 0; r < NumAddrRounds; r++) begin
      // Key mixing
      state = state ^ key_i;
      // Nibble substitution, one group per 4 address bits
      for (int n = 0; n < Aw / 4; n++) begin
        state[4*n +: 4] = SBox[state[4*n +: 4]];
      end
      // Diffusion by a one-bit left rotation
      state = {state[Aw-2:0], state[Aw-1]};
    end
  end

  // Each step is a bijection, so the whole map is a permutation of rows
  assign addr_o = state;

endmodule

//--- hw/rom_scr_pkg.sv
/* Shared widths, word types, scrambling constants, S-box and
   round constants of the scrambled ROM */

package rom_scr_pkg;

  // ROM geometry
  localparam int Width = 40;
  localparam int Depth = 16;
  localparam int Aw    = $clog2(Depth);

  // Cipher geometry
  localparam int BlockWidth    = 64;
  localparam int NonceWidth    = BlockWidth - Aw;
  localparam int NumAddrRounds = 2;
  localparam int CipherRot     = 13;

  typedef logic [Width-1:0]      word_t;
  typedef logic [Aw-1:0]         addr_t;
  typedef logic [BlockWidth-1:0] block_t;
  typedef logic [127:0]          key_t;

  // Top Aw bits key the address, low bits feed the keystream
  localparam block_t ScrNonce = 64'h9e37_79b9_7f4a_7c15;

  // Upper half is k0, lower half is k1
  localparam key_t ScrKey = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;

  // PRESENT S-box
  localparam logic [3:0] SBox [16] = '{
    4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
    4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };

  // One constant per cipher round
  localparam block_t RoundConst [4] = '{
    64'h1319_8a2e_0370_7344,
    64'ha409_3822_299f_31d0,
    64'h082e_fa98_ec4e_6c89,
    64'h4528_21e6_38d0_1377
  };

  // Scrambled image, already in physical row order
  localparam string MemInitFile = "rom_image.hex";

endpackage
